//--- rtl/lumaPkg.sv
// Shared widths, transform and quantizer constants and types for the
// luma macroblock quantizer. Every design file imports it with a
// wildcard import in the module header.

`default_nettype none

package lumaPkg;

    // ------------------------------
    // Sizes and indices
    // ------------------------------
    localparam int BlkDim    = 4;
    localparam int MbDim     = 16;
    localparam int NumBlocks = 16;
    localparam int NumCoefs  = 16;

    typedef logic [3:0] blkIndexT;
    typedef logic [7:0] pixelT;

    // Raster order with pixel (r, c) at r*16+c
    typedef pixelT [MbDim*MbDim-1:0] macroblockT;
    // Sub-block pixel (i, j) at i*4+j
    typedef pixelT [BlkDim*BlkDim-1:0] pixBlockT;

    // ------------------------------
    // Coefficients and levels
    // ------------------------------
    typedef logic signed [15:0] coefT;
    typedef coefT [NumCoefs-1:0] coefBlockT;

    localparam int MaxLevel = 2047;
    localparam int QFix     = 17;

    // VP8 forward DCT constants
    localparam int DctK1    = 2217;
    localparam int DctK2    = 5352;
    localparam int RowRnd1  = 1812;
    localparam int RowRnd2  = 937;
    localparam int ColRnd1  = 12000;
    localparam int ColRnd2  = 51000;
    localparam int RowShift = 9;
    localparam int ColShift = 16;

    // ------------------------------
    // Quantizer matrix
    // ------------------------------
    // q is the dequantizer step and has no user without the
    // reconstruction path
    typedef struct packed {
        logic [15:0] q;
        logic [15:0] iq;
        logic [31:0] bias;
        logic [31:0] zthresh;
        logic [15:0] sharpen;
    } quantEntryT;

    typedef quantEntryT [NumCoefs-1:0] quantMatrixT;

    // Which sub-block a pipeline stage holds
    typedef struct packed {
        logic     valid;
        blkIndexT index;
    } blockTagT;

    typedef enum logic {
        Idle,
        Run
    } seqStateT;

endpackage

`default_nettype wire

//--- rtl/blockSequencer.sv
// Steps through the sixteen 4x4 sub-blocks of a macroblock, one per clock.
// A start pulse in Idle begins a run; the tag and the source and prediction
// pixels of each sub-block are registered for the transform stage.

`timescale 1ns/1ps
`default_nettype none

module blockSequencer
    import lumaPkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  macroblockT ySrc,
    input  macroblockT yPred,
    output blockTagT   seqTag,
    output pixBlockT   srcBlk,
    output pixBlockT   predBlk
);

    seqStateT state;
    blkIndexT blkCnt;
    pixBlockT srcSel;
    pixBlockT predSel;

    // Sub-block extraction for the current counter value
    always_comb begin
        int rowBase;
        int colBase;
        rowBase = int'(blkCnt[3:2]) * BlkDim;
        colBase = int'(blkCnt[1:0]) * BlkDim;
        for (int i = 0; i < BlkDim; i++) begin
            for (int j = 0; j < BlkDim; j++) begin
                srcSel[i*BlkDim+j]  = ySrc[(rowBase+i)*MbDim + colBase + j];
                predSel[i*BlkDim+j] = yPred[(rowBase+i)*MbDim + colBase + j];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= Idle;
            blkCnt <= '0;
            seqTag <= '0;
        end else begin
            seqTag <= '0;
            case (state)
                Idle: begin
                    if (start) begin
                        state  <= Run;
                        blkCnt <= '0;
                    end
                end
                Run: begin
                    seqTag <= '{valid: 1'b1, index: blkCnt};
                    blkCnt <= blkCnt + 4'd1;
                    // Last sub-block issued
                    if (blkCnt == blkIndexT'(NumBlocks-1)) begin
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        srcBlk  <= srcSel;
        predBlk <= predSel;
    end

endmodule

`default_nettype wire

//--- rtl/forwardDct.sv
// Residual and VP8 4x4 forward integer transform for one sub-block per
// clock. The whole transform is combinational and the tag and the sixteen
// coefficients are registered together, giving one cycle of latency.

`timescale 1ns/1ps
`default_nettype none

module forwardDct
    import lumaPkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  blockTagT  seqTag,
    input  pixBlockT  srcBlk,
    input  pixBlockT  predBlk,
    output blockTagT  dctTag,
    output coefBlockT dctCoef
);

    int        resid  [NumCoefs];
    int        rowOut [NumCoefs];
    coefBlockT coefNext;

    always_comb begin
        int a0;
        int a1;
        int a2;
        int a3;
        int colVal;

        for (int k = 0; k < NumCoefs; k++) begin
            resid[k] = int'(srcBlk[k]) - int'(predBlk[k]);
        end

        // ------------------------------
        // Row pass
        // ------------------------------
        for (int r = 0; r < BlkDim; r++) begin
            a0 = resid[4*r+0] + resid[4*r+3];
            a1 = resid[4*r+1] + resid[4*r+2];
            a2 = resid[4*r+1] - resid[4*r+2];
            a3 = resid[4*r+0] - resid[4*r+3];
            rowOut[4*r+0] = (a0 + a1) * 8;
            rowOut[4*r+1] = (a2 * DctK1 + a3 * DctK2 + RowRnd1) >>> RowShift;
            rowOut[4*r+2] = (a0 - a1) * 8;
            rowOut[4*r+3] = (a3 * DctK1 - a2 * DctK2 + RowRnd2) >>> RowShift;
        end

        // ------------------------------
        // Column pass
        // ------------------------------
        for (int i = 0; i < BlkDim; i++) begin
            a0 = rowOut[i] + rowOut[12+i];
            a1 = rowOut[4+i] + rowOut[8+i];
            a2 = rowOut[4+i] - rowOut[8+i];
            a3 = rowOut[i] - rowOut[12+i];

            coefNext[i] = coefT'((a0 + a1 + 7) >>> 4);

            colVal = (a2 * DctK1 + a3 * DctK2 + ColRnd1) >>> ColShift;
            // Bias toward nonzero when a3 carries energy
            if (a3 != 0) begin
                colVal = colVal + 1;
            end
            coefNext[4+i] = coefT'(colVal);

            coefNext[8+i]  = coefT'((a0 - a1 + 7) >>> 4);
            coefNext[12+i] = coefT'((a3 * DctK1 - a2 * DctK2 + ColRnd2) >>> ColShift);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dctTag <= '0;
        end else begin
            dctTag <= seqTag;
        end
    end

    always_ff @(posedge clk) begin
        dctCoef <= coefNext;
    end

endmodule

`default_nettype wire

//--- rtl/coefQuant.sv
// One quantizer lane. Turns a transform coefficient into a signed level
// clamped to MaxLevel, using the inverse step, bias, zero threshold and
// sharpening of its quantizer matrix entry. One cycle of latency.

`timescale 1ns/1ps
`default_nettype none

module coefQuant
    import lumaPkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  coefT       coef,
    input  quantEntryT entry,
    output coefT       level
);

    logic signed [16:0] coefExt;
    logic [16:0]        absVal;
    logic [17:0]        mag;
    logic [47:0]        scaled;
    logic [10:0]        clamped;
    coefT               levelNext;

    always_comb begin
        coefExt = coef;
        absVal  = coefExt[16] ? 17'(-coefExt) : 17'(coefExt);
        mag     = 18'(absVal) + 18'(entry.sharpen);

        scaled = (48'(mag) * 48'(entry.iq) + 48'(entry.bias)) >> QFix;

        // Clamp before the sign goes back on
        if (scaled > 48'(MaxLevel)) begin
            clamped = 11'(MaxLevel);
        end else begin
            clamped = scaled[10:0];
        end

        if (32'(mag) > entry.zthresh) begin
            levelNext = coef[15] ? -coefT'(clamped) : coefT'(clamped);
        end else begin
            levelNext = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level <= '0;
        end else begin
            level <= levelNext;
        end
    end

endmodule

`default_nettype wire

//--- rtl/levelCollector.sv
// Stores the quantized levels of each sub-block at its index together with
// a per-block nonzero flag. The tag from the transform is delayed one cycle
// to line up with the quantizer lanes. done falls when block 0 is stored and
// rises when block 15 is stored.

`timescale 1ns/1ps
`default_nettype none

module levelCollector
    import lumaPkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  blockTagT                   dctTag,
    input  coefBlockT                  laneLevels,
    output coefBlockT [NumBlocks-1:0]  levels,
    output logic      [NumBlocks-1:0]  nz,
    output logic                       done
);

    blockTagT laneTag;
    logic     anyNonzero;

    assign anyNonzero = |laneLevels;

    // Lanes add one cycle behind the transform
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            laneTag <= '0;
        end else begin
            laneTag <= dctTag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            levels <= '0;
            nz     <= '0;
            done   <= 1'b0;
        end else if (laneTag.valid) begin
            levels[laneTag.index] <= laneLevels;
            nz[laneTag.index]     <= anyNonzero;
            if (laneTag.index == '0) begin
                done <= 1'b0;
            end
            if (laneTag.index == blkIndexT'(NumBlocks-1)) begin
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/lumaQuantTop.sv
// Top level of the luma macroblock quantizer. Pulse start with ySrc, yPred
// and qm stable; levels and nz are valid once done goes high and stay
// there until the next accepted start.

`timescale 1ns/1ps
`default_nettype none

module lumaQuantTop
    import lumaPkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  macroblockT                ySrc,
    input  macroblockT                yPred,
    input  quantMatrixT               qm,
    output coefBlockT [NumBlocks-1:0] levels,
    output logic      [NumBlocks-1:0] nz,
    output logic                      done
);

    blockTagT  seqTag;
    pixBlockT  srcBlk;
    pixBlockT  predBlk;
    blockTagT  dctTag;
    coefBlockT dctCoef;
    coefBlockT laneLevels;

    blockSequencer seq0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .ySrc    (ySrc),
        .yPred   (yPred),
        .seqTag  (seqTag),
        .srcBlk  (srcBlk),
        .predBlk (predBlk)
    );

    forwardDct dct0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .seqTag  (seqTag),
        .srcBlk  (srcBlk),
        .predBlk (predBlk),
        .dctTag  (dctTag),
        .dctCoef (dctCoef)
    );

    // One lane per coefficient position
    for (genvar c = 0; c < NumCoefs; c++) begin : gLane
        coefQuant lane (
            .clk   (clk),
            .rst_n (rst_n),
            .coef  (dctCoef[c]),
            .entry (qm[c]),
            .level (laneLevels[c])
        );
    end

    levelCollector col0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .dctTag     (dctTag),
        .laneLevels (laneLevels),
        .levels     (levels),
        .nz         (nz),
        .done       (done)
    );

endmodule

`default_nettype wire

//--- tests/lumaQuant_sva.sv
// Protocol assertions for the luma quantizer top level, attached with bind.
// Shadows the sequencer run window to recognise an accepted start.

`timescale 1ns/1ps
`default_nettype none

module lumaQuantSva
    import lumaPkg::*;
(
    input logic                 clk,
    input logic                 rst_n,
    input logic                 start,
    input blockTagT             seqTag,
    input logic [NumBlocks-1:0] nz,
    input logic                 done
);

    logic     busy;
    blkIndexT busyCnt;
    logic     accepted;

    assign accepted = start && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            busyCnt <= '0;
        end else if (accepted) begin
            busy    <= 1'b1;
            busyCnt <= '0;
        end else if (busy) begin
            busyCnt <= busyCnt + 4'd1;
            if (busyCnt == blkIndexT'(NumBlocks-1)) busy <= 1'b0;
        end
    end

    // done is set by the edge 19 cycles after the start edge
    doneLatency: assert property (@(posedge clk) disable iff (!rst_n)
        accepted |-> ##20 $rose(done))
        else $error("done did not rise 19 cycles after an accepted start");

    tagBurst: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(seqTag.valid) |-> ##16 !seqTag.valid)
        else $error("seqTag.valid stayed high longer than 16 cycles");

    nzHold: assert property (@(posedge clk) disable iff (!rst_n)
        (done && $past(done)) |-> $stable(nz))
        else $error("nz changed while done was high");

endmodule

bind lumaQuantTop lumaQuantSva sva0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .seqTag (seqTag),
    .nz     (nz),
    .done   (done)
);

`default_nettype wire

//--- tests/lumaQuantTb.sv
// Testbench for the luma macroblock quantizer. Random macroblocks and
// quantizer matrices come from an LFSR; a model recomputes every level and
// nonzero flag, which are compared once done is high. Run by make test.

`timescale 1ns/1ps
`default_nettype none

module lumaQuantTb
    import lumaPkg::*;
();

    localparam int ClkPeriod  = 8;
    localparam int NumRandom  = 20;
    localparam int NumRuns    = NumRandom + 3;
    localparam int DoneCycles = 19;

    logic                      clk;
    logic                      rst_n;
    logic                      start;
    macroblockT                ySrc;
    macroblockT                yPred;
    quantMatrixT               qm;
    coefBlockT [NumBlocks-1:0] levels;
    logic      [NumBlocks-1:0] nz;
    logic                      done;

    coefBlockT            expLevels [NumBlocks];
    logic [NumBlocks-1:0] expNz;
    logic [31:0]          lfsr;
    int                   errors;
    int                   checks;

    lumaQuantTop dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .ySrc   (ySrc),
        .yPred  (yPred),
        .qm     (qm),
        .levels (levels),
        .nz     (nz),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod/2) clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic randomizeInputs(input bit sameSrc, input bit highThresh);
        for (int p = 0; p < MbDim*MbDim; p++) begin
            ySrc[p]  = pixelT'(randBits(8));
            yPred[p] = sameSrc ? ySrc[p] : pixelT'(randBits(8));
        end
        for (int c = 0; c < NumCoefs; c++) begin
            qm[c].q       = 16'(randBits(16));
            qm[c].iq      = 16'(randBits(12));
            qm[c].bias    = randBits(17);
            qm[c].zthresh = randBits(8);
            qm[c].sharpen = 16'(randBits(4));
            if (qm[c].iq == 16'd0) qm[c].iq = 16'd1;
            // Zero residual still leaves coefficient 1 at 1
            if (highThresh) qm[c].zthresh = qm[c].zthresh | 32'd16;
        end
    endtask

    task automatic fillBlock(input int k, input pixelT s, input pixelT p);
        int idx;
        for (int i = 0; i < BlkDim; i++) begin
            for (int j = 0; j < BlkDim; j++) begin
                idx = (4*(k/4) + i)*MbDim + 4*(k%4) + j;
                ySrc[idx]  = s;
                yPred[idx] = p;
            end
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic computeModel();
        int     d [4][4];
        int     t [4][4];
        int     cf [NumCoefs];
        int     x0;
        int     x1;
        int     x2;
        int     x3;
        int     pix;
        longint mag;
        longint lv;
        for (int k = 0; k < NumBlocks; k++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    pix = (4*(k/4) + i)*MbDim + 4*(k%4) + j;
                    d[i][j] = int'(ySrc[pix]) - int'(yPred[pix]);
                end
            end
            for (int i = 0; i < 4; i++) begin
                x0 = d[i][0] + d[i][3];
                x1 = d[i][1] + d[i][2];
                x2 = d[i][1] - d[i][2];
                x3 = d[i][0] - d[i][3];
                t[i][0] = (x0 + x1) * 8;
                t[i][1] = (x2*DctK1 + x3*DctK2 + RowRnd1) >>> RowShift;
                t[i][2] = (x0 - x1) * 8;
                t[i][3] = (x3*DctK1 - x2*DctK2 + RowRnd2) >>> RowShift;
            end
            for (int j = 0; j < 4; j++) begin
                x0 = t[0][j] + t[3][j];
                x1 = t[1][j] + t[2][j];
                x2 = t[1][j] - t[2][j];
                x3 = t[0][j] - t[3][j];
                cf[j]    = (x0 + x1 + 7) >>> 4;
                cf[4+j]  = ((x2*DctK1 + x3*DctK2 + ColRnd1) >>> ColShift) + ((x3 != 0) ? 1 : 0);
                cf[8+j]  = (x0 - x1 + 7) >>> 4;
                cf[12+j] = (x3*DctK1 - x2*DctK2 + ColRnd2) >>> ColShift;
            end
            expNz[k] = 1'b0;
            for (int c = 0; c < NumCoefs; c++) begin
                mag = (cf[c] < 0) ? -cf[c] : cf[c];
                mag = mag + longint'(qm[c].sharpen);
                lv  = 0;
                if (mag > longint'(qm[c].zthresh)) begin
                    lv = (mag * longint'(qm[c].iq) + longint'(qm[c].bias)) >>> QFix;
                    if (lv > MaxLevel) lv = MaxLevel;
                    if (cf[c] < 0) lv = -lv;
                end
                expLevels[k][c] = coefT'(lv);
                if (lv != 0) expNz[k] = 1'b1;
            end
        end
    endtask

    // Pulse start, optionally pulse it again mid-run, then wait for done and compare
    task automatic runAndCheck(input bit secondStart);
        int cyc;
        computeModel();
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        cyc = 0;
        while (!(done && cyc > 4) && cyc < 2*DoneCycles) begin
            @(posedge clk);
            #1;
            cyc++;
            if (secondStart) start = (cyc == 4);
        end
        checks++;
        assert (cyc == DoneCycles) else begin
            errors++;
            $display("FAIL %0t: done after %0d cycles, expected %0d", $time, cyc, DoneCycles);
        end
        for (int k = 0; k < NumBlocks; k++) begin
            for (int c = 0; c < NumCoefs; c++) begin
                checks++;
                assert (levels[k][c] == expLevels[k][c]) else begin
                    errors++;
                    $display("FAIL %0t: block %0d coef %0d level %0d, expected %0d",
                             $time, k, c, levels[k][c], expLevels[k][c]);
                end
            end
        end
        checks++;
        assert (nz == expNz) else begin
            errors++;
            $display("FAIL %0t: nz %h, expected %h", $time, nz, expNz);
        end
    endtask

    initial begin
        lfsr   = 32'h7d10_64c8;
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        start  = 1'b0;
        ySrc   = '0;
        yPred  = '0;
        qm     = '0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1;
        checks++;
        assert (done == 1'b0 && nz == '0 && levels == '0) else begin
            errors++;
            $display("FAIL %0t: outputs not cleared after reset", $time);
        end

        for (int r = 0; r < NumRandom; r++) begin
            randomizeInputs(1'b0, 1'b0);
            runAndCheck(1'b0);
        end

        // Source equals prediction
        randomizeInputs(1'b1, 1'b1);
        runAndCheck(1'b0);
        checks++;
        assert (nz == '0 && levels == '0) else begin
            errors++;
            $display("FAIL %0t: zero residual gave nz %h", $time, nz);
        end

        // Full-scale blocks with a bias large enough to clamp every passing level
        randomizeInputs(1'b1, 1'b0);
        fillBlock(0, 8'd255, 8'd0);
        fillBlock(5, 8'd0, 8'd255);
        fillBlock(10, 8'd255, 8'd0);
        fillBlock(15, 8'd0, 8'd255);
        for (int c = 0; c < NumCoefs; c++) begin
            qm[c] = '{q: 16'(randBits(16)), iq: 16'd4095, bias: 32'h1000_0000,
                      zthresh: 32'd0, sharpen: 16'd0};
        end
        runAndCheck(1'b0);
        checks++;
        assert (levels[0][0] == coefT'(MaxLevel) && levels[10][0] == coefT'(MaxLevel) &&
                levels[5][0] == -coefT'(MaxLevel) && levels[15][0] == -coefT'(MaxLevel))
        else begin
            errors++;
            $display("FAIL %0t: DC levels %0d %0d %0d %0d, expected +-%0d", $time,
                     levels[0][0], levels[5][0], levels[10][0], levels[15][0], MaxLevel);
        end

        // Second start while running
        randomizeInputs(1'b0, 1'b0);
        runAndCheck(1'b1);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #((NumRuns*40 + 200) * ClkPeriod);
        $display("Watchdog expired before all runs finished");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
rtl/lumaPkg.sv
rtl/blockSequencer.sv
rtl/forwardDct.sv
rtl/coefQuant.sv
rtl/levelCollector.sv
rtl/lumaQuantTop.sv
tests/lumaQuant_sva.sv
tests/lumaQuantTb.sv

//--- Makefile
# Verilator build and run for the luma quantizer testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= lumaQuantTb
BUILD_DIR ?= obj_dir
FILELIST  ?= build.f
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR VFLAGS TOP BUILD_DIR FILELIST"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
